// File: Makefile
VERILATOR ?= verilator
TOP       ?= clockLaneTxTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation finished: PASS

.DEFAULT_GOAL := help
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_TEXT)" $(LOG) || { echo "Test failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/clockLaneTxTb.sv
`default_nettype none
`timescale 1ns/1ps

`include "clockLane_settings.svh"

module clockLaneTxTb;
    import clockLanePkg::*;

    localparam int clkPeriod  = 20;
    localparam int holdCycles = 8;
    localparam int stepMargin = 4;

    // One table entry: request to drive and the response to wait for
    typedef struct {
        ppiRequest_t     request;
        ppiStatus_t      status;
        int              limit;
        lineState_t      line;
        bit              toggling;
        logic [0:3][2:0] seq;
        int              seqLen;
    } step_t;

    logic        ppi = 1'b0;
    logic        hs_clk;
    ppiRequest_t request;
    ppiStatus_t  status;
    lineState_t  line;

    step_t      steps[$];
    // Distinct line states in the order seen during the current step
    logic [2:0] history[$];
    int         budgetCycles;
    bit         tableBuilt;
    int         checkErrors;
    int         timeouts;

    clockLaneTx clockLaneTx_i (
        .ppi     (ppi),
        .hs_clk  (hs_clk),
        .request (request),
        .status  (status),
        .line    (line)
    );

    always #(clkPeriod / 2) ppi = ~ppi;

    function automatic ppiRequest_t makeRequest(input bit en, input bit hs, input bit idle,
                                                input bit ulps, input bit ulpsExit);
        ppiRequest_t r;
        r.enable        = en;
        r.txRequestHs   = hs;
        r.txHsIdleClkHs = idle;
        r.txUlpsClk     = ulps;
        r.txUlpsExit    = ulpsExit;
        return r;
    endfunction

    function automatic ppiStatus_t makeStatus(input bit stop, input bit ready,
                                              input bit idleReady, input bit ulpsNot);
        ppiStatus_t s;
        s.stopState          = stop;
        s.txReadyHs          = ready;
        s.txHsIdleClkReadyHs = idleReady;
        s.ulpsActiveNot      = ulpsNot;
        return s;
    endfunction

    function automatic void addStep(input ppiRequest_t req, input ppiStatus_t st,
                                    input int limit, input lineState_t ln, input bit tog,
                                    input logic [0:3][2:0] seq, input int seqLen);
        step_t s;
        s.request  = req;
        s.status   = st;
        s.limit    = limit;
        s.line     = ln;
        s.toggling = tog;
        s.seq      = seq;
        s.seqLen   = seqLen;
        steps.push_back(s);
        budgetCycles += limit + holdCycles + 2;
    endfunction

    function automatic void buildTable();
        ppiRequest_t off;
        ppiRequest_t idle;
        ppiRequest_t hsOn;
        ppiStatus_t  stopped;
        ppiStatus_t  inactive;
        ppiStatus_t  ready;
        off      = makeRequest(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        idle     = makeRequest(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        hsOn     = makeRequest(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        stopped  = makeStatus(1'b1, 1'b0, 1'b0, 1'b1);
        inactive = makeStatus(1'b0, 1'b0, 1'b0, 1'b1);
        ready    = makeStatus(1'b0, 1'b1, 1'b0, 1'b1);
        addStep(off, inactive, 2, LP11, 1'b0, {LP11, LP11, LP11, LP11}, 1);
        addStep(idle, stopped, `INIT_CYCLES + 1 + stepMargin, LP11, 1'b0,
                {LP11, LP11, LP11, LP11}, 1);
        addStep(hsOn, ready, `LPX_CYCLES + `CLK_PREPARE_CYCLES + `CLK_ZERO_CYCLES
                + `CLK_PRE_CYCLES + 1 + stepMargin, HS1, 1'b1, {LP01, LP00, HS0, HS1}, 4);
        // HS idle entry and release
        addStep(makeRequest(1'b1, 1'b1, 1'b1, 1'b0, 1'b0), makeStatus(1'b0, 1'b0, 1'b1, 1'b1),
                `IDLE_POST_CYCLES + `IDLE_MIN_CYCLES + 1 + stepMargin, HS0, 1'b0,
                {HS0, HS0, HS0, HS0}, 1);
        addStep(hsOn, ready, `IDLE_PRE_CYCLES + 1 + stepMargin, HS1, 1'b1,
                {HS1, HS0, HS0, HS0}, 2);
        // HS finish has to end on HS0 right before LP11
        addStep(idle, stopped, `CLK_TRAIL_HS_CYCLES + `CLK_TRAIL_CYCLES + `HS_EXIT_CYCLES
                + 1 + stepMargin, LP11, 1'b0, {HS0, LP11, LP11, LP11}, 2);
        addStep(makeRequest(1'b1, 1'b0, 1'b0, 1'b1, 1'b0), makeStatus(1'b0, 1'b0, 1'b0, 1'b0),
                `LPX_CYCLES + 1 + stepMargin, LP00, 1'b0, {LP10, LP00, LP00, LP00}, 2);
        addStep(makeRequest(1'b1, 1'b0, 1'b0, 1'b1, 1'b1), inactive, 1 + stepMargin, LP10,
                1'b0, {LP00, LP10, LP10, LP10}, 2);
        addStep(idle, stopped, `WAKEUP_CYCLES + 2 + stepMargin, LP11, 1'b0,
                {LP10, LP11, LP11, LP11}, 2);
        // Shutdown in the middle of HS clocking, then a fresh power-up
        addStep(hsOn, ready, `LPX_CYCLES + `CLK_PREPARE_CYCLES + `CLK_ZERO_CYCLES
                + `CLK_PRE_CYCLES + 1 + stepMargin, HS1, 1'b1, {LP01, LP00, HS0, HS1}, 4);
        addStep(off, inactive, 2, LP11, 1'b0, {LP11, LP11, LP11, LP11}, 1);
        addStep(idle, stopped, `INIT_CYCLES + 1 + stepMargin, LP11, 1'b0,
                {LP11, LP11, LP11, LP11}, 1);
    endfunction

    task automatic waitCycle();
        @(negedge ppi);
        if (history.size() == 0 || history[$] != line)
            history.push_back(line);
    endtask

    function automatic bit containsSequence(input logic [0:3][2:0] seq, input int seqLen);
        bit found;
        bit same;
        found = 1'b0;
        for (int i = 0; i + seqLen <= history.size(); i++)
        begin
            same = 1'b1;
            for (int k = 0; k < seqLen; k++)
                if (history[i + k] != seq[k])
                    same = 1'b0;
            if (same)
                found = 1'b1;
        end
        return found;
    endfunction

    task automatic checkHold(input int idx, input step_t s, input lineState_t prevLine);
        assert (status == s.status)
        else
        begin
            checkErrors++;
            $display("CHECK FAILED at %0t: step %0d status %b, expected %b held",
                     $time, idx, status, s.status);
        end
        if (s.toggling)
        begin
            assert ((line == HS0 || line == HS1) && line != prevLine)
            else
            begin
                checkErrors++;
                $display("CHECK FAILED at %0t: step %0d line %s after %s, expected HS toggle",
                         $time, idx, line.name(), prevLine.name());
            end
        end
        else
        begin
            assert (line == s.line)
            else
            begin
                checkErrors++;
                $display("CHECK FAILED at %0t: step %0d line %s, expected %s",
                         $time, idx, line.name(), s.line.name());
            end
        end
    endtask

    task automatic runStep(input int idx, input step_t s);
        int         cycles;
        bit         matched;
        lineState_t prevLine;
        @(posedge ppi);
        request <= s.request;
        history.delete();
        cycles  = 0;
        matched = 1'b0;
        while (!matched && cycles < s.limit)
        begin
            waitCycle();
            cycles++;
            matched = (status == s.status);
        end
        if (!matched)
        begin
            timeouts++;
            $display("Step %0d timed out: status is %b and never reached %b in %0d cycles",
                     idx, status, s.status, s.limit);
        end
        // Line follows the phase one cycle later
        waitCycle();
        prevLine = line;
        for (int k = 0; k < holdCycles; k++)
        begin
            waitCycle();
            checkHold(idx, s, prevLine);
            prevLine = line;
        end
        assert (containsSequence(s.seq, s.seqLen))
        else
        begin
            checkErrors++;
            $display("CHECK FAILED at %0t: step %0d expected line order not seen",
                     $time, idx);
        end
    endtask

    initial
    begin
        hs_clk       <= 1'b0;
        request      <= '0;
        checkErrors  = 0;
        timeouts     = 0;
        budgetCycles = 10;
        buildTable();
        tableBuilt   = 1'b1;
        repeat (2) @(posedge ppi);
        hs_clk <= 1'b1;
        foreach (steps[i])
            runStep(i, steps[i]);
        $display("Summary: %0d check errors, %0d step timeouts in %0d steps",
                 checkErrors, timeouts, steps.size());
        if (checkErrors == 0 && timeouts == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // Run budget is the sum of all step limits plus some slack
    initial
    begin
        wait (tableBuilt);
        #(budgetCycles * clkPeriod);
        $display("Watchdog expired: the run did not end within %0d cycles", budgetCycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/clockLanePkg.sv
`default_nettype none

`include "clockLane_settings.svh"

package clockLanePkg;

    // Remaining cycles of the current phase
    typedef logic [`TIMER_WIDTH-1:0] timerCount_t;

    // Clock lane line states, Mark-1 is LP10
    typedef enum logic [2:0]
    {
        LP00 = 3'd0,
        LP01 = 3'd1,
        LP10 = 3'd2,
        LP11 = 3'd3,
        HS0  = 3'd4,
        HS1  = 3'd5
    } lineState_t;

    // Lane control FSM states
    typedef enum logic [4:0]
    {
        phaseOff, phaseInit, phaseStop,
        phaseHsRequest, phaseHsPrepare, phaseHsZero, phaseHsPre, phaseHsActive,
        phaseHsTrail, phaseClkTrail, phaseHsExit,
        phaseIdlePost, phaseIdleMin, phaseIdleWait, phaseIdlePre,
        phaseUlpsEntry, phaseUlps, phaseUlpsWakeup, phaseUlpsHold
    } lanePhase_t;

    // PPI requests from the protocol layer
    typedef struct packed
    {
        logic enable;
        logic txRequestHs;
        logic txHsIdleClkHs;
        logic txUlpsClk;
        logic txUlpsExit;
    } ppiRequest_t;

    // PPI status back to the protocol layer
    typedef struct packed
    {
        logic stopState;
        logic txReadyHs;
        logic txHsIdleClkReadyHs;
        logic ulpsActiveNot;
    } ppiStatus_t;

endpackage

`default_nettype wire

// File: design/clockLaneTx.sv
`default_nettype none
`timescale 1ns/1ps

module clockLaneTx (
    input  logic                      ppi,
    input  logic                      hs_clk,
    input  clockLanePkg::ppiRequest_t request,
    output clockLanePkg::ppiStatus_t  status,
    output clockLanePkg::lineState_t  line
);
    import clockLanePkg::*;

    // Current lane phase shared by all blocks
    lanePhase_t phase;
    // Timed phase reaches its last cycle
    logic       expired;

    laneControlFsm laneControlFsm_i (
        .ppi     (ppi),
        .hs_clk  (hs_clk),
        .request (request),
        .expired (expired),
        .phase   (phase),
        .status  (status)
    );

    phaseTimer phaseTimer_i (
        .ppi     (ppi),
        .hs_clk  (hs_clk),
        .phase   (phase),
        .expired (expired)
    );

    lineDriver lineDriver_i (
        .ppi    (ppi),
        .hs_clk (hs_clk),
        .phase  (phase),
        .line   (line)
    );

endmodule

`default_nettype wire

// File: design/clockLane_settings.svh
`ifndef CLOCKLANE_SETTINGS_SVH
`define CLOCKLANE_SETTINGS_SVH

// Phase timer counter width
`define TIMER_WIDTH 8

// Phase durations in ppi cycles, one cycle per UI

// Power-up initialization in LP11
`define INIT_CYCLES 20

// Low-power request states
`define LPX_CYCLES 4

// HS clock start-up
`define CLK_PREPARE_CYCLES 3
`define CLK_ZERO_CYCLES 10
`define CLK_PRE_CYCLES 8

// HS finish, trail and post merged into one count
`define CLK_TRAIL_HS_CYCLES 12
`define CLK_TRAIL_CYCLES 4
`define HS_EXIT_CYCLES 5

// HS Tx idle
`define IDLE_POST_CYCLES 4
`define IDLE_MIN_CYCLES 6
`define IDLE_PRE_CYCLES 4

// Mark-1 hold before leaving ULPS
`define WAKEUP_CYCLES 30

`endif

// File: design/laneControlFsm.sv
`default_nettype none
`timescale 1ns/1ps

module laneControlFsm (
    input  logic                      ppi,
    input  logic                      hs_clk,
    input  clockLanePkg::ppiRequest_t request,
    input  logic                      expired,
    output clockLanePkg::lanePhase_t  phase,
    output clockLanePkg::ppiStatus_t  status
);
    import clockLanePkg::*;

    lanePhase_t nextPhase;

    // Status seen while the lane sits in a given phase
    function automatic ppiStatus_t statusFor(input lanePhase_t p);
        ppiStatus_t s;
        s.stopState          = (p == phaseStop);
        // Ready from clock start until the end of post, and again after idle pre
        s.txReadyHs          = (p == phaseHsActive) || (p == phaseHsTrail)
                               || (p == phaseIdlePost);
        s.txHsIdleClkReadyHs = (p == phaseIdleWait);
        s.ulpsActiveNot      = (p != phaseUlps);
        return s;
    endfunction

    always_comb
    begin
        nextPhase = phase;
        if (!request.enable)
        begin
            // Shutdown wins over everything
            nextPhase = phaseOff;
        end
        else
        begin
            case (phase)
                phaseOff:
                begin
                    nextPhase = phaseInit;
                end
                phaseInit:
                begin
                    if (expired)
                        nextPhase = phaseStop;
                end
                phaseStop:
                begin
                    if (request.txRequestHs)
                        nextPhase = phaseHsRequest;
                    else if (request.txUlpsClk)
                        nextPhase = phaseUlpsEntry;
                end

                // HS clock start-up
                phaseHsRequest:
                begin
                    if (expired)
                        nextPhase = phaseHsPrepare;
                end
                phaseHsPrepare:
                begin
                    if (expired)
                        nextPhase = phaseHsZero;
                end
                phaseHsZero:
                begin
                    if (expired)
                        nextPhase = phaseHsPre;
                end
                phaseHsPre:
                begin
                    if (expired)
                        nextPhase = phaseHsActive;
                end
                phaseHsActive:
                begin
                    if (!request.txRequestHs)
                        nextPhase = phaseHsTrail;
                    else if (request.txHsIdleClkHs)
                        nextPhase = phaseIdlePost;
                end

                // HS finish back to Stop
                phaseHsTrail:
                begin
                    if (expired)
                        nextPhase = phaseClkTrail;
                end
                phaseClkTrail:
                begin
                    if (expired)
                        nextPhase = phaseHsExit;
                end
                phaseHsExit:
                begin
                    if (expired)
                        nextPhase = phaseStop;
                end

                // HS Tx idle
                phaseIdlePost:
                begin
                    if (expired)
                        nextPhase = phaseIdleMin;
                end
                phaseIdleMin:
                begin
                    if (expired)
                        nextPhase = phaseIdleWait;
                end
                phaseIdleWait:
                begin
                    if (!request.txHsIdleClkHs)
                        nextPhase = phaseIdlePre;
                end
                phaseIdlePre:
                begin
                    if (expired)
                        nextPhase = phaseHsActive;
                end

                // ULPS entry, stay and wakeup
                phaseUlpsEntry:
                begin
                    if (expired)
                        nextPhase = phaseUlps;
                end
                phaseUlps:
                begin
                    if (request.txUlpsExit)
                        nextPhase = phaseUlpsWakeup;
                end
                phaseUlpsWakeup:
                begin
                    if (expired)
                        nextPhase = phaseUlpsHold;
                end
                phaseUlpsHold:
                begin
                    if (!request.txUlpsClk)
                        nextPhase = phaseStop;
                end
                default:
                begin
                    nextPhase = phaseOff;
                end
            endcase
        end
    end

    // Status moves on the same edge as the phase
    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            phase  <= phaseOff;
            status <= statusFor(phaseOff);
        end
        else
        begin
            phase  <= nextPhase;
            status <= statusFor(nextPhase);
        end
    end

endmodule

`default_nettype wire

// File: design/lineDriver.sv
`default_nettype none
`timescale 1ns/1ps

module lineDriver (
    input  logic                     ppi,
    input  logic                     hs_clk,
    input  clockLanePkg::lanePhase_t phase,
    output clockLanePkg::lineState_t line
);
    import clockLanePkg::*;

    logic toggling;
    logic hsHigh;

    // Phases that carry a running HS clock
    assign toggling = (phase == phaseHsPre) || (phase == phaseHsActive)
                      || (phase == phaseHsTrail) || (phase == phaseIdlePost)
                      || (phase == phaseIdlePre);

    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            hsHigh <= 1'b0;
            line   <= LP11;
        end
        else
        begin
            // Toggle flop drops back to HS0 outside the clocking phases
            hsHigh <= toggling ? ~hsHigh : 1'b0;
            case (phase)
                phaseHsRequest:  line <= LP01;
                phaseHsPrepare,
                phaseUlps:       line <= LP00;
                phaseHsZero,
                phaseClkTrail,
                phaseIdleMin,
                phaseIdleWait:   line <= HS0;
                phaseUlpsEntry,
                phaseUlpsWakeup,
                phaseUlpsHold:   line <= LP10;
                default:         line <= LP11;
            endcase
            if (toggling)
                line <= hsHigh ? HS0 : HS1;
        end
    end

endmodule

`default_nettype wire

// File: design/phaseTimer.sv
`default_nettype none
`timescale 1ns/1ps

`include "clockLane_settings.svh"

module phaseTimer (
    input  logic                     ppi,
    input  logic                     hs_clk,
    input  clockLanePkg::lanePhase_t phase,
    output logic                     expired
);
    import clockLanePkg::*;

    lanePhase_t  prevPhase;
    timerCount_t count;
    timerCount_t duration;
    timerCount_t remaining;
    logic        timed;

    // Duration of each timed phase
    always_comb
    begin
        timed    = 1'b1;
        duration = '0;
        case (phase)
            phaseInit:       duration = timerCount_t'(`INIT_CYCLES);
            phaseHsRequest:  duration = timerCount_t'(`LPX_CYCLES);
            phaseHsPrepare:  duration = timerCount_t'(`CLK_PREPARE_CYCLES);
            phaseHsZero:     duration = timerCount_t'(`CLK_ZERO_CYCLES);
            phaseHsPre:      duration = timerCount_t'(`CLK_PRE_CYCLES);
            phaseHsTrail:    duration = timerCount_t'(`CLK_TRAIL_HS_CYCLES);
            phaseClkTrail:   duration = timerCount_t'(`CLK_TRAIL_CYCLES);
            phaseHsExit:     duration = timerCount_t'(`HS_EXIT_CYCLES);
            phaseIdlePost:   duration = timerCount_t'(`IDLE_POST_CYCLES);
            phaseIdleMin:    duration = timerCount_t'(`IDLE_MIN_CYCLES);
            phaseIdlePre:    duration = timerCount_t'(`IDLE_PRE_CYCLES);
            phaseUlpsEntry:  duration = timerCount_t'(`LPX_CYCLES);
            phaseUlpsWakeup: duration = timerCount_t'(`WAKEUP_CYCLES);
            default:         timed    = 1'b0;
        endcase
    end

    // First cycle of a new phase counts from the full duration
    assign remaining = (phase != prevPhase) ? duration : count;
    assign expired   = timed && (remaining == timerCount_t'(1));

    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            prevPhase <= phaseOff;
            count     <= '0;
        end
        else
        begin
            prevPhase <= phase;
            count     <= timed ? remaining - 1'b1 : '0;
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
design/clockLanePkg.sv
design/phaseTimer.sv
design/laneControlFsm.sv
design/lineDriver.sv
design/clockLaneTx.sv
bench/clockLaneTxTb.sv
